// ==== source/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

    // Wishbone data width on every port
    localparam int data_width = 16;

    // Host word address with bit 6 selecting the memory window
    localparam int host_addr_width = 7;

    // Sample memory holds 64 words
    localparam int ram_addr_width = 6;

    // Register word addresses decoded from the low two address bits
    localparam logic [1:0] reg_ctrl = 2'd0;
    localparam logic [1:0] reg_duty = 2'd1;
    localparam logic [1:0] reg_length = 2'd2;
    localparam logic [1:0] reg_status = 2'd3;

    typedef enum logic [1:0] {
        fetch_idle,
        fetch_request,
        fetch_hold
    } fetch_state_t;

    typedef enum logic [1:0] {
        arb_idle,
        arb_busy_host,
        arb_busy_fetch
    } arb_state_t;

endpackage

`default_nettype wire

// ==== source/button_parser.sv ====
`default_nettype none

module button_parser #(
    parameter int sample_count_max = 25000,
    parameter int pulse_count_max = 200
) (
    input  logic       cpu_clk_g,
    input  logic       rst,
    input  logic [2:0] buttons,
    output logic [2:0] press
);

    localparam int sample_w = $clog2(sample_count_max);
    localparam int pulse_w = $clog2(pulse_count_max + 1);

    logic [2:0]          btn_meta;
    logic [2:0]          btn_sync;
    logic [sample_w-1:0] sample_cnt;
    logic                tick;
    logic [pulse_w-1:0]  hold_cnt [3];

    assign tick = (sample_cnt == sample_w'(sample_count_max - 1));

    // Two-stage synchronizer on the raw buttons
    always_ff @(posedge cpu_clk_g) begin
        btn_meta <= buttons;
        btn_sync <= btn_meta;
    end

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            sample_cnt <= '0;
            press <= '0;
            for (int i = 0; i < 3; i++) begin
                hold_cnt[i] <= '0;
            end
        end else begin
            sample_cnt <= tick ? '0 : sample_cnt + 1'b1;
            for (int i = 0; i < 3; i++) begin
                press[i] <= 1'b0;
                // Any low level restarts the count, so glitches never reach the limit
                if (!btn_sync[i]) begin
                    hold_cnt[i] <= '0;
                end else if (tick && hold_cnt[i] != pulse_w'(pulse_count_max)) begin
                    hold_cnt[i] <= hold_cnt[i] + 1'b1;
                    press[i] <= (hold_cnt[i] == pulse_w'(pulse_count_max - 1));
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/audio_ctrl_regs.sv ====
`default_nettype none

module audio_ctrl_regs #(
    parameter int duty_width = 8
) (
    input  logic                                 cpu_clk_g,
    input  logic                                 rst,
    input  logic                                 wb_cyc,
    input  logic                                 wb_stb,
    input  logic                                 wb_we,
    input  logic [audio_pkg::host_addr_width-1:0] wb_adr,
    input  logic [audio_pkg::data_width-1:0]      wb_dat_w,
    output logic [audio_pkg::data_width-1:0]      wb_dat_r,
    output logic                                 wb_ack,
    input  logic [2:0]                           press,
    output logic                                 m0_cyc,
    output logic                                 m0_stb,
    output logic                                 m0_we,
    output logic [audio_pkg::ram_addr_width-1:0] m0_adr,
    output logic [audio_pkg::data_width-1:0]      m0_dat_w,
    input  logic                                 m0_ack,
    input  logic [audio_pkg::data_width-1:0]      m0_dat_r,
    output logic                                 source_sel,
    output logic [duty_width-1:0]                direct_duty,
    output logic [audio_pkg::ram_addr_width-1:0] play_length
);

    logic                            win;
    logic                            reg_acc;
    logic                            reg_ack;
    logic [audio_pkg::data_width-1:0] reg_rdata;
    logic [2:0]                      status;
    logic [2:0]                      status_clr;

    // Top address bit selects the sample memory window
    assign win = wb_adr[audio_pkg::host_addr_width-1];
    assign reg_acc = wb_cyc & wb_stb & !win & !reg_ack;

    // Memory window goes straight out as arbiter master 0
    assign m0_cyc = wb_cyc & win;
    assign m0_stb = wb_stb & win;
    assign m0_we = wb_we;
    assign m0_adr = wb_adr[audio_pkg::ram_addr_width-1:0];
    assign m0_dat_w = wb_dat_w;

    assign wb_ack = win ? m0_ack : reg_ack;
    assign wb_dat_r = win ? m0_dat_r : reg_rdata;

    // Write one to clear
    assign status_clr = (reg_acc && wb_we && wb_adr[1:0] == audio_pkg::reg_status) ?
                        wb_dat_w[2:0] : 3'b000;

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            reg_ack <= 1'b0;
            source_sel <= 1'b0;
            direct_duty <= '0;
            play_length <= '0;
            status <= '0;
        end else begin
            reg_ack <= reg_acc;
            status <= (status & ~status_clr) | press;
            if (reg_acc && wb_we) begin
                case (wb_adr[1:0])
                    audio_pkg::reg_ctrl:   source_sel <= wb_dat_w[0];
                    audio_pkg::reg_duty:   direct_duty <= wb_dat_w[duty_width-1:0];
                    audio_pkg::reg_length: play_length <= wb_dat_w[audio_pkg::ram_addr_width-1:0];
                    default: ;
                endcase
            end
        end
    end

    // Read data is captured with the access and shown alongside the ack
    always_ff @(posedge cpu_clk_g) begin
        if (reg_acc) begin
            reg_rdata <= '0;
            case (wb_adr[1:0])
                audio_pkg::reg_ctrl:   reg_rdata[0] <= source_sel;
                audio_pkg::reg_duty:   reg_rdata[duty_width-1:0] <= direct_duty;
                audio_pkg::reg_length: reg_rdata[audio_pkg::ram_addr_width-1:0] <= play_length;
                default:               reg_rdata[2:0] <= status;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== source/wb_arbiter.sv ====
`default_nettype none

module wb_arbiter (
    input  logic                                 cpu_clk_g,
    input  logic                                 rst,
    input  logic                                 m0_cyc,
    input  logic                                 m0_stb,
    input  logic                                 m0_we,
    input  logic [audio_pkg::ram_addr_width-1:0] m0_adr,
    input  logic [audio_pkg::data_width-1:0]      m0_dat_w,
    output logic [audio_pkg::data_width-1:0]      m0_dat_r,
    output logic                                 m0_ack,
    input  logic                                 m1_cyc,
    input  logic                                 m1_stb,
    input  logic [audio_pkg::ram_addr_width-1:0] m1_adr,
    output logic [audio_pkg::data_width-1:0]      m1_dat_r,
    output logic                                 m1_ack,
    output logic                                 s_cyc,
    output logic                                 s_stb,
    output logic                                 s_we,
    output logic [audio_pkg::ram_addr_width-1:0] s_adr,
    output logic [audio_pkg::data_width-1:0]      s_dat_w,
    input  logic [audio_pkg::data_width-1:0]      s_dat_r,
    input  logic                                 s_ack
);

    audio_pkg::arb_state_t state;
    logic                  last_fetch;
    logic                  m0_req;
    logic                  m1_req;
    logic                  gnt_host;
    logic                  gnt_fetch;

    assign m0_req = m0_cyc & m0_stb;
    assign m1_req = m1_cyc & m1_stb;
    assign gnt_host = (state == audio_pkg::arb_busy_host);
    assign gnt_fetch = (state == audio_pkg::arb_busy_fetch);

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            state <= audio_pkg::arb_idle;
            last_fetch <= 1'b0;
        end else begin
            case (state)
                audio_pkg::arb_idle: begin
                    // On a tie the master that lost last time wins
                    if (m0_req && (!m1_req || last_fetch)) begin
                        state <= audio_pkg::arb_busy_host;
                        last_fetch <= 1'b0;
                    end else if (m1_req) begin
                        state <= audio_pkg::arb_busy_fetch;
                        last_fetch <= 1'b1;
                    end
                end
                audio_pkg::arb_busy_host: begin
                    if (s_ack || !m0_cyc) begin
                        state <= audio_pkg::arb_idle;
                    end
                end
                audio_pkg::arb_busy_fetch: begin
                    if (s_ack || !m1_cyc) begin
                        state <= audio_pkg::arb_idle;
                    end
                end
                default: state <= audio_pkg::arb_idle;
            endcase
        end
    end

    // Only the owner reaches the memory; master 1 only reads
    assign s_cyc = (gnt_host & m0_cyc) | (gnt_fetch & m1_cyc);
    assign s_stb = (gnt_host & m0_stb) | (gnt_fetch & m1_stb);
    assign s_we = gnt_host & m0_we;
    assign s_adr = gnt_fetch ? m1_adr : m0_adr;
    assign s_dat_w = m0_dat_w;

    assign m0_ack = gnt_host & s_ack;
    assign m1_ack = gnt_fetch & s_ack;
    assign m0_dat_r = s_dat_r;
    assign m1_dat_r = s_dat_r;

endmodule

`default_nettype wire

// ==== source/sample_ram.sv ====
`default_nettype none

module sample_ram (
    input  logic                                 cpu_clk_g,
    input  logic                                 s_cyc,
    input  logic                                 s_stb,
    input  logic                                 s_we,
    input  logic [audio_pkg::ram_addr_width-1:0] s_adr,
    input  logic [audio_pkg::data_width-1:0]      s_dat_w,
    output logic [audio_pkg::data_width-1:0]      s_dat_r,
    output logic                                 s_ack
);

    logic [audio_pkg::data_width-1:0] mem [0:(1 << audio_pkg::ram_addr_width)-1];
    logic                            access;

    // A request already being acked is not served twice
    assign access = s_cyc & s_stb & !s_ack;

    always_ff @(posedge cpu_clk_g) begin
        s_ack <= access;
    end

    always_ff @(posedge cpu_clk_g) begin
        if (access) begin
            if (s_we) begin
                mem[s_adr] <= s_dat_w;
            end
            s_dat_r <= mem[s_adr];
        end
    end

endmodule

`default_nettype wire

// ==== source/wave_fetcher.sv ====
`default_nettype none

module wave_fetcher #(
    parameter int duty_width = 8,
    parameter int sample_div = 256
) (
    input  logic                                 cpu_clk_g,
    input  logic                                 rst,
    input  logic [audio_pkg::ram_addr_width-1:0] play_length,
    input  logic                                 m1_ack,
    input  logic [audio_pkg::data_width-1:0]      m1_dat_r,
    output logic                                 m1_cyc,
    output logic                                 m1_stb,
    output logic [audio_pkg::ram_addr_width-1:0] m1_adr,
    output logic [duty_width-1:0]                play_duty
);

    localparam int div_w = $clog2(sample_div);

    audio_pkg::fetch_state_t             state;
    logic [div_w-1:0]                    rate_cnt;
    logic                                tick;
    logic [audio_pkg::ram_addr_width-1:0] index;

    assign tick = (rate_cnt == div_w'(sample_div - 1));

    // Free-running sample rate counter
    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= tick ? '0 : rate_cnt + 1'b1;
        end
    end

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            state <= audio_pkg::fetch_idle;
            index <= '0;
            play_duty <= '0;
        end else begin
            case (state)
                audio_pkg::fetch_idle: begin
                    if (tick) begin
                        state <= audio_pkg::fetch_request;
                    end
                end
                audio_pkg::fetch_request: begin
                    if (m1_ack) begin
                        play_duty <= m1_dat_r[duty_width-1:0];
                        // Wrap also if LENGTH shrank below the current index
                        index <= (index >= play_length) ? '0 : index + 1'b1;
                        state <= audio_pkg::fetch_hold;
                    end
                end
                // One idle cycle so stb drops after the ack
                audio_pkg::fetch_hold: state <= audio_pkg::fetch_idle;
                default: state <= audio_pkg::fetch_idle;
            endcase
        end
    end

    assign m1_cyc = (state == audio_pkg::fetch_request);
    assign m1_stb = (state == audio_pkg::fetch_request);
    assign m1_adr = index;

endmodule

`default_nettype wire

// ==== source/pwm_dac.sv ====
`default_nettype none

module pwm_dac #(
    parameter int duty_width = 8
) (
    input  logic                  cpu_clk_g,
    input  logic                  rst,
    input  logic                  source_sel,
    input  logic [duty_width-1:0] direct_duty,
    input  logic [duty_width-1:0] play_duty,
    output logic                  pwm,
    output logic                  dac_source
);

    logic [duty_width-1:0] period_cnt;
    logic [duty_width-1:0] active_duty;

    always_ff @(posedge cpu_clk_g) begin
        if (rst) begin
            period_cnt <= '0;
            active_duty <= '0;
            dac_source <= 1'b0;
        end else begin
            period_cnt <= period_cnt + 1'b1;
            dac_source <= source_sel;
            // New duty only at the wrap, so no period is split
            if (&period_cnt) begin
                active_duty <= dac_source ? play_duty : direct_duty;
            end
        end
    end

    // Duty 0 keeps the output low for the whole period
    assign pwm = (period_cnt < active_duty);

endmodule

`default_nettype wire

// ==== source/audio_top.sv ====
`default_nettype none

module audio_top #(
    parameter int duty_width = 8,
    parameter int sample_div = 256,
    parameter int sample_count_max = 25000,
    parameter int pulse_count_max = 200
) (
    input  logic                                  cpu_clk_g,
    input  logic                                  rst,
    input  logic                                  wb_cyc,
    input  logic                                  wb_stb,
    input  logic                                  wb_we,
    input  logic [audio_pkg::host_addr_width-1:0] wb_adr,
    input  logic [audio_pkg::data_width-1:0]      wb_dat_w,
    output logic [audio_pkg::data_width-1:0]      wb_dat_r,
    output logic                                  wb_ack,
    input  logic [2:0]                            buttons,
    output logic                                  pwm,
    output logic                                  dac_source
);

    logic [2:0]                           press;
    logic                                 source_sel;
    logic [duty_width-1:0]                direct_duty;
    logic [duty_width-1:0]                play_duty;
    logic [audio_pkg::ram_addr_width-1:0] play_length;

    // Host side of the memory
    logic                                 m0_cyc;
    logic                                 m0_stb;
    logic                                 m0_we;
    logic                                 m0_ack;
    logic [audio_pkg::ram_addr_width-1:0] m0_adr;
    logic [audio_pkg::data_width-1:0]      m0_dat_w;
    logic [audio_pkg::data_width-1:0]      m0_dat_r;

    // Fetcher side of the memory
    logic                                 m1_cyc;
    logic                                 m1_stb;
    logic                                 m1_ack;
    logic [audio_pkg::ram_addr_width-1:0] m1_adr;
    logic [audio_pkg::data_width-1:0]      m1_dat_r;

    logic                                 s_cyc;
    logic                                 s_stb;
    logic                                 s_we;
    logic                                 s_ack;
    logic [audio_pkg::ram_addr_width-1:0] s_adr;
    logic [audio_pkg::data_width-1:0]      s_dat_w;
    logic [audio_pkg::data_width-1:0]      s_dat_r;

    button_parser #(
        .sample_count_max(sample_count_max),
        .pulse_count_max(pulse_count_max)
    ) button_parser_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .buttons(buttons),
        .press(press)
    );

    audio_ctrl_regs #(
        .duty_width(duty_width)
    ) audio_ctrl_regs_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .press(press),
        .m0_cyc(m0_cyc),
        .m0_stb(m0_stb),
        .m0_we(m0_we),
        .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w),
        .m0_ack(m0_ack),
        .m0_dat_r(m0_dat_r),
        .source_sel(source_sel),
        .direct_duty(direct_duty),
        .play_length(play_length)
    );

    wb_arbiter wb_arbiter_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .m0_cyc(m0_cyc),
        .m0_stb(m0_stb),
        .m0_we(m0_we),
        .m0_adr(m0_adr),
        .m0_dat_w(m0_dat_w),
        .m0_dat_r(m0_dat_r),
        .m0_ack(m0_ack),
        .m1_cyc(m1_cyc),
        .m1_stb(m1_stb),
        .m1_adr(m1_adr),
        .m1_dat_r(m1_dat_r),
        .m1_ack(m1_ack),
        .s_cyc(s_cyc),
        .s_stb(s_stb),
        .s_we(s_we),
        .s_adr(s_adr),
        .s_dat_w(s_dat_w),
        .s_dat_r(s_dat_r),
        .s_ack(s_ack)
    );

    sample_ram sample_ram_inst (
        .cpu_clk_g(cpu_clk_g),
        .s_cyc(s_cyc),
        .s_stb(s_stb),
        .s_we(s_we),
        .s_adr(s_adr),
        .s_dat_w(s_dat_w),
        .s_dat_r(s_dat_r),
        .s_ack(s_ack)
    );

    wave_fetcher #(
        .duty_width(duty_width),
        .sample_div(sample_div)
    ) wave_fetcher_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .play_length(play_length),
        .m1_ack(m1_ack),
        .m1_dat_r(m1_dat_r),
        .m1_cyc(m1_cyc),
        .m1_stb(m1_stb),
        .m1_adr(m1_adr),
        .play_duty(play_duty)
    );

    pwm_dac #(
        .duty_width(duty_width)
    ) pwm_dac_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .source_sel(source_sel),
        .direct_duty(direct_duty),
        .play_duty(play_duty),
        .pwm(pwm),
        .dac_source(dac_source)
    );

endmodule

`default_nettype wire

// ==== tests/audio_top_checker.sv ====
`default_nettype none

module audio_top_checker (
    input logic                                  cpu_clk_g,
    input logic                                  rst,
    input logic                                  wb_cyc,
    input logic                                  wb_stb,
    input logic [audio_pkg::host_addr_width-1:0] wb_adr,
    input logic                                  wb_ack,
    input logic                                  m0_cyc,
    input logic                                  m0_stb,
    input logic                                  m0_ack,
    input logic                                  m1_cyc,
    input logic                                  m1_stb,
    input logic                                  m1_ack,
    input logic                                  s_cyc,
    input logic                                  s_stb,
    input logic                                  s_ack
);

    timeunit 1ns;
    timeprecision 100ps;

    logic reg_window;

    assign reg_window = !wb_adr[audio_pkg::host_addr_width-1];

    // Every ack needs the request that it answers
    host_ack_qualified: assert property (@(posedge cpu_clk_g) disable iff (rst)
        wb_ack |-> wb_cyc && wb_stb)
        else $error("host ack without cyc and stb");
    m0_ack_qualified: assert property (@(posedge cpu_clk_g) disable iff (rst)
        m0_ack |-> m0_cyc && m0_stb)
        else $error("master 0 ack without cyc and stb");
    m1_ack_qualified: assert property (@(posedge cpu_clk_g) disable iff (rst)
        m1_ack |-> m1_cyc && m1_stb)
        else $error("master 1 ack without cyc and stb");
    mem_ack_qualified: assert property (@(posedge cpu_clk_g) disable iff (rst)
        s_ack |-> s_cyc && s_stb)
        else $error("memory ack without cyc and stb");

    // A memory ack goes to exactly one owner
    grant_one_hot: assert property (@(posedge cpu_clk_g) disable iff (rst)
        s_ack |-> $onehot({m0_ack, m1_ack}))
        else $error("memory ack routed to both or neither master");

    // A new register request is acked in the next cycle and for that cycle only
    reg_ack_one_cycle: assert property (@(posedge cpu_clk_g) disable iff (rst)
        wb_cyc && wb_stb && reg_window && !($past(wb_cyc && wb_stb) && !$past(wb_ack))
        |=> wb_ack ##1 !wb_ack)
        else $error("register access not acked for exactly one cycle");

endmodule

bind audio_top audio_top_checker audio_top_checker_inst (.*);

`default_nettype wire

// ==== tests/audio_top_tb.sv ====
`default_nettype none

module audio_top_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int duty_width = 8;
    localparam int period_len = 256;
    localparam int pulse_limit = 1000;

    typedef logic [audio_pkg::data_width-1:0] data_t;
    typedef logic [audio_pkg::host_addr_width-1:0] addr_t;

    logic                  cpu_clk_g;
    logic                  rst;
    logic                  wb_cyc;
    logic                  wb_stb;
    logic                  wb_we;
    addr_t                 wb_adr;
    data_t                 wb_dat_w;
    data_t                 wb_dat_r;
    logic                  wb_ack;
    logic [2:0]            buttons;
    logic                  pwm;
    logic                  dac_source;

    int                    seed;
    int                    check_total;
    int                    error_total;
    int                    timeout_total;
    data_t                 mem_model [64];
    logic [duty_width-1:0] samples [4];

    audio_top #(
        .duty_width(duty_width),
        .sample_div(period_len),
        .sample_count_max(4),
        .pulse_count_max(3)
    ) audio_top_inst (
        .cpu_clk_g(cpu_clk_g),
        .rst(rst),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_dat_w(wb_dat_w),
        .wb_dat_r(wb_dat_r),
        .wb_ack(wb_ack),
        .buttons(buttons),
        .pwm(pwm),
        .dac_source(dac_source)
    );

    initial begin
        cpu_clk_g = 1'b0;
        forever #50 cpu_clk_g = ~cpu_clk_g;
    end

    // Inputs change and outputs are sampled 10 ns after the edge
    task automatic next_cycle;
        @(posedge cpu_clk_g);
        #10;
    endtask

    function automatic addr_t reg_address(input logic [1:0] r);
        return addr_t'(r);
    endfunction

    function automatic addr_t mem_address(input int a);
        return {1'b1, 6'(a)};
    endfunction

    task automatic check_data(input string name, input data_t got, input data_t exp);
        check_total++;
        if (got !== exp) begin
            error_total++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        check_total++;
        if (got !== exp) begin
            error_total++;
            $display("FAILED at %0t: %s is %b, expected %b", $time, name, got, exp);
        end
    endtask

    task automatic wb_access(input logic we, input addr_t adr, input data_t wdat,
                             output data_t rdat);
        int n;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we = we;
        wb_adr = adr;
        wb_dat_w = wdat;
        n = 0;
        do begin
            next_cycle();
            n++;
        end while (wb_ack !== 1'b1 && n < 20);
        if (wb_ack !== 1'b1) begin
            timeout_total++;
            $display("Timeout at %0t: no ack from the host port at address %h", $time, adr);
        end
        rdat = wb_dat_r;
        // Master releases the bus in the cycle after the ack
        next_cycle();
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
    endtask

    task automatic wb_write(input addr_t adr, input data_t wdat);
        data_t unused;
        wb_access(1'b1, adr, wdat, unused);
    endtask

    task automatic wb_read(input addr_t adr, output data_t rdat);
        wb_access(1'b0, adr, '0, rdat);
    endtask

    task automatic wait_rise;
        int n;
        n = 0;
        while (pwm !== 1'b0 && n < pulse_limit) begin
            next_cycle();
            n++;
        end
        while (pwm !== 1'b1 && n < pulse_limit) begin
            next_cycle();
            n++;
        end
        if (n >= pulse_limit) begin
            timeout_total++;
            $display("Timeout at %0t: pwm never rose", $time);
        end
    endtask

    // Starts on the first high sample, returns on the next rise
    task automatic measure_pulse(output int high_cycles, output int period);
        high_cycles = 0;
        period = 0;
        while (pwm === 1'b1 && period < pulse_limit) begin
            next_cycle();
            high_cycles++;
            period++;
        end
        while (pwm === 1'b0 && period < pulse_limit) begin
            next_cycle();
            period++;
        end
        if (period >= pulse_limit) begin
            timeout_total++;
            $display("Timeout at %0t: pwm pulse did not complete", $time);
        end
    endtask

    task automatic check_direct_duty(input logic [duty_width-1:0] d);
        int high_cycles;
        int period;
        wb_write(reg_address(audio_pkg::reg_duty), data_t'(d));
        wait_rise();
        measure_pulse(high_cycles, period);
        repeat (2) begin
            measure_pulse(high_cycles, period);
            check_data("pwm high time", data_t'(high_cycles), data_t'(d));
            check_data("pwm period", data_t'(period), data_t'(period_len));
        end
    endtask

    task automatic check_playback(input int pulses);
        int high_cycles;
        int period;
        int k;
        k = -1;
        wait_rise();
        repeat (2) measure_pulse(high_cycles, period);
        measure_pulse(high_cycles, period);
        for (int i = 0; i < 4; i++) begin
            if (data_t'(samples[i]) == data_t'(high_cycles)) begin
                k = i;
            end
        end
        if (k < 0) begin
            error_total++;
            $display("At %0t the pwm pulse of %0d cycles matches no loaded sample",
                     $time, high_cycles);
        end else begin
            for (int j = 0; j < pulses; j++) begin
                k = (k + 1) % 4;
                measure_pulse(high_cycles, period);
                check_data("pwm high time", data_t'(high_cycles), data_t'(samples[k]));
                check_data("pwm period", data_t'(period), data_t'(period_len));
            end
        end
    endtask

    task automatic hold_button(input int idx, input int cycles);
        buttons[idx] = 1'b1;
        repeat (cycles) next_cycle();
        buttons[idx] = 1'b0;
        repeat (10) next_cycle();
    endtask

    task automatic test_registers;
        data_t rdat;
        wb_read(reg_address(audio_pkg::reg_status), rdat);
        check_data("STATUS", rdat, '0);
        wb_write(reg_address(audio_pkg::reg_ctrl), 16'h0001);
        wb_write(reg_address(audio_pkg::reg_duty), 16'h005a);
        wb_write(reg_address(audio_pkg::reg_length), 16'h0015);
        wb_read(reg_address(audio_pkg::reg_ctrl), rdat);
        check_data("CTRL", rdat, 16'h0001);
        wb_read(reg_address(audio_pkg::reg_duty), rdat);
        check_data("DUTY", rdat, 16'h005a);
        wb_read(reg_address(audio_pkg::reg_length), rdat);
        check_data("LENGTH", rdat, 16'h0015);
        check_bit("dac_source", dac_source, 1'b1);
        wb_write(reg_address(audio_pkg::reg_ctrl), 16'h0000);
        check_bit("dac_source", dac_source, 1'b0);
    endtask

    task automatic test_memory;
        data_t rdat;
        for (int a = 0; a < 64; a++) begin
            mem_model[a] = data_t'($random(seed));
            wb_write(mem_address(a), mem_model[a]);
        end
        for (int a = 0; a < 64; a++) begin
            wb_read(mem_address(a), rdat);
            check_data("wb_dat_r", rdat, mem_model[a]);
        end
    endtask

    task automatic test_direct_pwm;
        logic seen_high;
        check_direct_duty(8'd1);
        check_direct_duty(8'd77);
        check_direct_duty(8'd200);
        check_direct_duty(8'd255);
        // The running period finishes before zero duty takes effect
        wb_write(reg_address(audio_pkg::reg_duty), 16'h0000);
        repeat (period_len + 20) next_cycle();
        seen_high = 1'b0;
        repeat (2 * period_len + 50) begin
            next_cycle();
            seen_high = seen_high | pwm;
        end
        check_bit("pwm", seen_high, 1'b0);
    endtask

    task automatic test_buttons;
        data_t rdat;
        hold_button(0, 30);
        hold_button(1, 5);
        hold_button(2, 30);
        wb_read(reg_address(audio_pkg::reg_status), rdat);
        check_data("STATUS", rdat, 16'h0005);
        wb_write(reg_address(audio_pkg::reg_status), 16'h0001);
        wb_read(reg_address(audio_pkg::reg_status), rdat);
        check_data("STATUS", rdat, 16'h0004);
        wb_write(reg_address(audio_pkg::reg_status), 16'h0004);
        wb_read(reg_address(audio_pkg::reg_status), rdat);
        check_data("STATUS", rdat, 16'h0000);
    endtask

    task automatic test_playback;
        // Distinct nonzero samples spread over the duty range
        for (int i = 0; i < 4; i++) begin
            samples[i] = duty_width'(30 + 55 * i + ($random(seed) & 15));
            mem_model[i] = data_t'(samples[i]);
            wb_write(mem_address(i), mem_model[i]);
        end
        wb_write(reg_address(audio_pkg::reg_length), 16'h0003);
        wb_write(reg_address(audio_pkg::reg_ctrl), 16'h0001);
        check_playback(8);
    endtask

    task automatic test_contention;
        data_t rdat;
        fork
            begin
                for (int round = 0; round < 4; round++) begin
                    for (int a = 4; a < 64; a++) begin
                        wb_read(mem_address(a), rdat);
                        check_data("wb_dat_r", rdat, mem_model[a]);
                    end
                end
            end
            check_playback(8);
        join
    endtask

    // Watchdog over the whole run
    initial begin
        for (int n = 0; n < 60000; n++) begin
            @(posedge cpu_clk_g);
        end
        $display("Simulation ran past its cycle limit");
        $display("Test failed");
        $finish;
    end

    initial begin
        seed = 32'hcff1;
        check_total = 0;
        error_total = 0;
        timeout_total = 0;
        rst = 1'b1;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we = 1'b0;
        wb_adr = '0;
        wb_dat_w = '0;
        buttons = 3'b000;
        repeat (4) next_cycle();
        rst = 1'b0;
        next_cycle();
        test_registers();
        test_memory();
        test_direct_pwm();
        test_buttons();
        test_playback();
        test_contention();
        $display("Checks: %0d, errors: %0d, timeouts: %0d",
                 check_total, error_total, timeout_total);
        if (error_total == 0 && timeout_total == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== audio_top.f ====
source/audio_pkg.sv
source/button_parser.sv
source/audio_ctrl_regs.sv
source/wb_arbiter.sv
source/sample_ram.sv
source/wave_fetcher.sv
source/pwm_dac.sv
source/audio_top.sv
tests/audio_top_checker.sv
tests/audio_top_tb.sv

// ==== Makefile ====
OBJ_DIR = obj_dir
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --timescale 1ns/100ps \
		--top-module audio_top_tb -f audio_top.f -Mdir $(OBJ_DIR) -o audio_top_sim

run: compile
	./$(OBJ_DIR)/audio_top_sim | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
